// File: rtl/bus_pkg.sv
package bus_pkg;

	// Bus widths
	localparam int ADDR_WIDTH = 16;
	localparam int DATA_WIDTH = 8;
	localparam int RAM_ADDR_WIDTH = 11;

	// Byte address seen on APB and on the system bus
	typedef logic [ADDR_WIDTH-1:0] addr_t;

	// One bus datum
	typedef logic [DATA_WIDTH-1:0] data_t;

	// Word index into the 2 kB RAM
	typedef logic [RAM_ADDR_WIDTH-1:0] ram_addr_t;

	// RAM at $0000 to $07FF
	localparam addr_t RAM_BASE = 16'h0000;
	localparam addr_t RAM_SIZE = 16'h0800;

	// Audio register block, one 256 byte page
	localparam addr_t REG_BASE = 16'h1000;

endpackage

// File: rtl/audio_pkg.sv
package audio_pkg;

	// One unsigned 8-bit sample
	typedef logic [7:0] sample_t;

	// Clock cycles between two samples
	typedef logic [15:0] period_t;

	// Samples in the loop, minus one
	typedef logic [10:0] length_t;

	// Register offsets inside the register page
	// 16-bit registers take the high byte at offset + 1
	localparam logic [7:0] OFS_CTRL = 8'h00;
	localparam logic [7:0] OFS_BASE = 8'h04;
	localparam logic [7:0] OFS_LENGTH = 8'h08;
	localparam logic [7:0] OFS_PERIOD = 8'h0c;
	localparam logic [7:0] OFS_STATUS = 8'h10;

	// Sample fetcher states
	typedef enum logic [1:0] {
		IDLE,
		WAIT,
		FETCH
	} fetch_state_t;

endpackage

// File: rtl/host_bridge.sv
`timescale 1ns/1ps

module host_bridge import bus_pkg::*, audio_pkg::*; #(
	parameter int PERIOD_WIDTH = 16
) (
	input logic sys,
	input logic rst_n,
	// APB slave
	input logic psel,
	input logic penable,
	input logic pwrite,
	input addr_t paddr,
	input data_t pwdata,
	output data_t prdata,
	output logic pready,
	output logic pslverr,
	// System bus master
	output logic host_req,
	output logic host_we,
	output addr_t host_addr,
	output data_t host_wdata,
	input logic host_gnt,
	input data_t rd_data,
	// Audio control
	output logic enable,
	output addr_t base,
	output length_t length,
	output logic [PERIOD_WIDTH-1:0] period,
	input logic wrap,
	output logic irq
);

typedef enum logic [1:0] {
	ACC_IDLE,
	ACC_REQ,
	ACC_DATA
} acc_state_t;

acc_state_t state, state_next;
addr_t ram_off;
logic ram_hit;
logic reg_page;
logic reg_hit;
logic first_access;
logic reg_wr;
logic [7:0] offset;
data_t reg_rdata;
period_t period_r;

// Address decode
assign ram_off = paddr - RAM_BASE;
assign ram_hit = ram_off < RAM_SIZE;
assign reg_page = paddr[15:8] == REG_BASE[15:8];
assign offset = paddr[7:0];

// First cycle of an APB access phase
assign first_access = psel & penable & (state == ACC_IDLE);
assign reg_wr = first_access & ~ram_hit & reg_hit & pwrite;

// Register read mux, also flags the valid offsets
always_comb begin
	reg_hit = 1'b0;
	reg_rdata = '0;
	if (reg_page) begin
		reg_hit = 1'b1;
		case (offset)
		OFS_CTRL: reg_rdata = {7'b0, enable};
		OFS_BASE: reg_rdata = base[7:0];
		OFS_BASE + 8'd1: reg_rdata = base[15:8];
		OFS_LENGTH: reg_rdata = length[7:0];
		OFS_LENGTH + 8'd1: reg_rdata = {5'b0, length[10:8]};
		OFS_PERIOD: reg_rdata = period_r[7:0];
		OFS_PERIOD + 8'd1: reg_rdata = period_r[15:8];
		OFS_STATUS: reg_rdata = {7'b0, irq};
		default: reg_hit = 1'b0;
		endcase
	end
end

// APB response
assign pready = (first_access & ~ram_hit) | (state == ACC_DATA);
assign pslverr = first_access & ~ram_hit & ~reg_hit;
assign prdata = (state == ACC_DATA) ? rd_data : reg_rdata;

// RAM request, held until granted
assign host_req = (first_access & ram_hit) | (state == ACC_REQ);
assign host_we = pwrite;
assign host_addr = paddr;
assign host_wdata = pwdata;

always_comb begin
	state_next = state;
	case (state)
	ACC_IDLE: if (first_access && ram_hit)
		state_next = host_gnt ? ACC_DATA : ACC_REQ;
	ACC_REQ: if (host_gnt)
		state_next = ACC_DATA;
	default: state_next = ACC_IDLE;
	endcase
end

always_ff @(posedge sys) begin
	if (!rst_n)
		state <= ACC_IDLE;
	else
		state <= state_next;
end

// Audio registers and sticky irq
always_ff @(posedge sys) begin
	if (!rst_n) begin
		enable <= 1'b0;
		base <= '0;
		length <= '0;
		period_r <= '0;
		irq <= 1'b0;
	end else begin
		if (reg_wr) begin
			case (offset)
			OFS_CTRL: enable <= pwdata[0];
			OFS_BASE: base[7:0] <= pwdata;
			OFS_BASE + 8'd1: base[15:8] <= pwdata;
			OFS_LENGTH: length[7:0] <= pwdata;
			OFS_LENGTH + 8'd1: length[10:8] <= pwdata[2:0];
			OFS_PERIOD: period_r[7:0] <= pwdata;
			OFS_PERIOD + 8'd1: period_r[15:8] <= pwdata;
			default: ;
			endcase
		end
		// A wrap in the same cycle as the clear wins
		if (wrap)
			irq <= 1'b1;
		else if (reg_wr && offset == OFS_STATUS && pwdata[0])
			irq <= 1'b0;
	end
end

assign period = period_r[PERIOD_WIDTH-1:0];

endmodule

// File: rtl/sample_fetcher.sv
`timescale 1ns/1ps

module sample_fetcher import bus_pkg::*, audio_pkg::*; #(
	parameter int PERIOD_WIDTH = 16
) (
	input logic sys,
	input logic rst_n,
	// Control from the register block
	input logic enable,
	input addr_t base,
	input length_t length,
	input logic [PERIOD_WIDTH-1:0] period,
	// System bus master, read only
	output logic fetch_req,
	output addr_t fetch_addr,
	input logic fetch_gnt,
	input data_t rd_data,
	// Audio out
	output sample_t audio,
	output logic wrap
);

fetch_state_t state;
logic [PERIOD_WIDTH-1:0] count;
length_t index;
logic last;
logic load;

assign fetch_req = state == FETCH;
assign fetch_addr = base + addr_t'(index);
assign last = index == length;

always_ff @(posedge sys) begin
	if (!rst_n) begin
		state <= IDLE;
		count <= '0;
		index <= '0;
		load <= 1'b0;
		wrap <= 1'b0;
	end else begin
		load <= 1'b0;
		wrap <= 1'b0;
		case (state)
		IDLE: begin
			if (enable) begin
				state <= WAIT;
				count <= period;
			end
		end
		WAIT: begin
			if (!enable) begin
				state <= IDLE;
				index <= '0;
			end else if (count <= PERIOD_WIDTH'(1)) begin
				state <= FETCH;
			end else begin
				count <= count - PERIOD_WIDTH'(1);
			end
		end
		FETCH: begin
			if (!enable) begin
				state <= IDLE;
				index <= '0;
			end else if (fetch_gnt) begin
				// Read happens at this edge, data arrives next cycle
				state <= WAIT;
				count <= period;
				load <= 1'b1;
				wrap <= last;
				index <= last ? '0 : index + length_t'(1);
			end
		end
		default: state <= IDLE;
		endcase
	end
end

// Sample register, holds its value while stopped
always_ff @(posedge sys) begin
	if (!rst_n)
		audio <= '0;
	else if (load)
		audio <= rd_data;
end

endmodule

// File: rtl/bus_fabric.sv
`timescale 1ns/1ps

module bus_fabric import bus_pkg::*; (
	input logic sys,
	input logic rst_n,
	// Host master
	input logic host_req,
	input logic host_we,
	input addr_t host_addr,
	input data_t host_wdata,
	output logic host_gnt,
	// Fetch master
	input logic fetch_req,
	input addr_t fetch_addr,
	output logic fetch_gnt,
	// Shared read data
	output data_t rd_data
);

data_t mem [0:RAM_SIZE-1];
addr_t sel_addr;
ram_addr_t ram_addr;
logic access;
logic wr_en;

// Fixed priority, audio fetch first
assign fetch_gnt = fetch_req;
assign host_gnt = host_req & ~fetch_req;

// Winner's address onto the RAM
assign sel_addr = fetch_gnt ? fetch_addr : host_addr;
assign ram_addr = ram_addr_t'(sel_addr - RAM_BASE);

assign access = fetch_gnt | host_gnt;
assign wr_en = host_gnt & host_we;

// 2 kB RAM array
always_ff @(posedge sys) begin
	if (wr_en)
		mem[ram_addr] <= host_wdata;
end

// Read data valid the cycle after the grant
always_ff @(posedge sys) begin
	if (!rst_n)
		rd_data <= '0;
	else if (access && !wr_en)
		rd_data <= mem[ram_addr];
end

endmodule

// File: rtl/system.sv
`timescale 1ns/1ps

module system import bus_pkg::*, audio_pkg::*; #(
	parameter int PERIOD_WIDTH = 16
) (
	input logic sys,
	input logic n_reset_in,
	// APB slave
	input logic psel,
	input logic penable,
	input logic pwrite,
	input addr_t paddr,
	input data_t pwdata,
	output data_t prdata,
	output logic pready,
	output logic pslverr,
	// Audio
	output sample_t audio,
	output logic irq
);

// Reset reformation
logic n_reset;

always_ff @(posedge sys) begin
	n_reset <= n_reset_in;
end

// Request/grant bus
logic host_req, host_we, host_gnt;
addr_t host_addr;
data_t host_wdata;
logic fetch_req, fetch_gnt;
addr_t fetch_addr;
data_t rd_data;

// Audio control
logic enable;
logic wrap;
addr_t base;
length_t length;
logic [PERIOD_WIDTH-1:0] period;

host_bridge #(.PERIOD_WIDTH(PERIOD_WIDTH)) i_bridge (
	.sys(sys), .rst_n(n_reset),
	.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
	.prdata(prdata), .pready(pready), .pslverr(pslverr),
	.host_req(host_req), .host_we(host_we), .host_addr(host_addr),
	.host_wdata(host_wdata), .host_gnt(host_gnt), .rd_data(rd_data),
	.enable(enable), .base(base), .length(length), .period(period),
	.wrap(wrap), .irq(irq));

sample_fetcher #(.PERIOD_WIDTH(PERIOD_WIDTH)) i_fetcher (
	.sys(sys), .rst_n(n_reset),
	.enable(enable), .base(base), .length(length), .period(period),
	.fetch_req(fetch_req), .fetch_addr(fetch_addr), .fetch_gnt(fetch_gnt),
	.rd_data(rd_data), .audio(audio), .wrap(wrap));

bus_fabric i_fabric (
	.sys(sys), .rst_n(n_reset),
	.host_req(host_req), .host_we(host_we), .host_addr(host_addr),
	.host_wdata(host_wdata), .host_gnt(host_gnt),
	.fetch_req(fetch_req), .fetch_addr(fetch_addr), .fetch_gnt(fetch_gnt),
	.rd_data(rd_data));

endmodule

// File: tb/system_assertions.sv
`timescale 1ns/1ps

module system_assertions (
	input logic sys,
	input logic n_reset,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic host_req,
	input logic host_gnt,
	input logic fetch_req,
	input logic fetch_gnt,
	input logic irq
);

// Only one master reaches the RAM per cycle
one_grant: assert property (@(posedge sys) disable iff (!n_reset)
	!(host_gnt && fetch_gnt))
	else $error("host and fetch grants high together");

host_gnt_req: assert property (@(posedge sys) disable iff (!n_reset)
	host_gnt |-> host_req)
	else $error("host grant without a host request");

fetch_gnt_req: assert property (@(posedge sys) disable iff (!n_reset)
	fetch_gnt |-> fetch_req)
	else $error("fetch grant without a fetch request");

// APB completes only inside an access phase
ready_in_access: assert property (@(posedge sys) disable iff (!n_reset)
	pready |-> (psel && penable))
	else $error("pready outside an APB access phase");

irq_in_reset: assert property (@(posedge sys) !n_reset |=> !irq)
	else $error("irq high during reset");

endmodule

bind system system_assertions i_assertions (
	.sys(sys), .n_reset(n_reset),
	.psel(psel), .penable(penable), .pready(pready),
	.host_req(host_req), .host_gnt(host_gnt),
	.fetch_req(fetch_req), .fetch_gnt(fetch_gnt),
	.irq(irq));

// File: tb/tb_system.sv
`timescale 1ns/1ps

module tb_system import bus_pkg::*, audio_pkg::*; ();

localparam int PERIOD_WIDTH = 16;
localparam int LOOP_SIZE = 16;
localparam int APB_TIMEOUT = 100;
localparam int SAMPLE_TIMEOUT = 400;

logic sys;
logic n_reset_in;
logic psel;
logic penable;
logic pwrite;
addr_t paddr;
data_t pwdata;
data_t prdata;
logic pready;
logic pslverr;
sample_t audio;
logic irq;

// Reference model of the RAM contents and the playback position
data_t model_ram [0:2047];
addr_t known[$];
addr_t play_base;
int play_idx;
sample_t last_audio;

string test_name;
int error_count;
int check_count;
int errors_before;
int tests_run;
int tests_failed;

system #(.PERIOD_WIDTH(PERIOD_WIDTH)) i_dut (
	.sys(sys), .n_reset_in(n_reset_in),
	.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
	.prdata(prdata), .pready(pready), .pslverr(pslverr),
	.audio(audio), .irq(irq));

initial begin
	sys = 1'b0;
	forever #50 sys = ~sys;
end

task automatic abort_run(input string reason);
	$display("Run stopped in test %s: %s", test_name, reason);
	$display("Verification failed");
	$finish;
endtask

task automatic check(input string what, input int expected, input int actual);
	check_count++;
	if (expected != actual) begin
		error_count++;
		$display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
	end
endtask

task automatic begin_test(input string name);
	test_name = name;
	errors_before = error_count;
endtask

task automatic end_test();
	tests_run++;
	if (error_count == errors_before) begin
		$display("test %s: ok", test_name);
	end else begin
		tests_failed++;
		$display("test %s: %0d errors", test_name, error_count - errors_before);
	end
endtask

function automatic data_t rand_byte();
	return 8'($urandom());
endfunction

function automatic addr_t reg_addr(input logic [7:0] ofs);
	return REG_BASE + addr_t'(ofs);
endfunction

// One APB transfer with setup and access phase until pready
task automatic apb_access(input logic write, input addr_t addr, input data_t wdata,
		output data_t rdata, output logic err);
	int cycles;
	@(posedge sys);
	#1;
	psel = 1'b1;
	penable = 1'b0;
	pwrite = write;
	paddr = addr;
	pwdata = wdata;
	@(posedge sys);
	#1;
	penable = 1'b1;
	cycles = 0;
	@(negedge sys);
	while (!pready) begin
		cycles++;
		if (cycles > APB_TIMEOUT)
			abort_run($sformatf("APB transfer to %04h never got pready", addr));
		@(negedge sys);
	end
	rdata = prdata;
	err = pslverr;
	@(posedge sys);
	#1;
	psel = 1'b0;
	penable = 1'b0;
endtask

task automatic write_ok(input addr_t a, input data_t d);
	data_t rd;
	logic err;
	apb_access(1'b1, a, d, rd, err);
	check($sformatf("pslverr on write %04h", a), 0, int'(err));
endtask

task automatic read_ok(input addr_t a, output data_t d);
	logic err;
	apb_access(1'b0, a, '0, d, err);
	check($sformatf("pslverr on read %04h", a), 0, int'(err));
endtask

task automatic ram_write(input addr_t a, input data_t d);
	write_ok(a, d);
	model_ram[a[10:0]] = d;
	known.push_back(a);
endtask

task automatic ram_check(input addr_t a);
	data_t d;
	read_ok(a, d);
	check($sformatf("ram[%03h]", a), int'(model_ram[a[10:0]]), int'(d));
endtask

// 16-bit registers take the low byte first
task automatic write_reg16(input logic [7:0] ofs, input logic [15:0] v);
	write_ok(reg_addr(ofs), v[7:0]);
	write_ok(reg_addr(ofs + 8'd1), v[15:8]);
endtask

task automatic check_reg16(input string name, input logic [7:0] ofs, input logic [15:0] v);
	data_t d;
	read_ok(reg_addr(ofs), d);
	check({name, " low"}, int'(v[7:0]), int'(d));
	read_ok(reg_addr(ofs + 8'd1), d);
	check({name, " high"}, int'(v[15:8]), int'(d));
endtask

function automatic logic is_register(input logic [7:0] ofs);
	case (ofs)
	OFS_CTRL, OFS_BASE, OFS_BASE + 8'd1, OFS_LENGTH, OFS_LENGTH + 8'd1,
	OFS_PERIOD, OFS_PERIOD + 8'd1, OFS_STATUS: return 1'b1;
	default: return 1'b0;
	endcase
endfunction

// Half of the picks land in the register page
function automatic addr_t unmapped_addr();
	addr_t a;
	do begin
		if ($urandom_range(0, 1) == 1)
			a = {REG_BASE[15:8], rand_byte()};
		else
			a = addr_t'($urandom());
	end while (a < RAM_SIZE || (a[15:8] == REG_BASE[15:8] && is_register(a[7:0])));
	return a;
endfunction

task automatic next_sample(output sample_t s);
	int cycles;
	cycles = 0;
	@(negedge sys);
	while (audio == last_audio) begin
		cycles++;
		if (cycles > SAMPLE_TIMEOUT)
			abort_run("audio output stopped changing during playback");
		@(negedge sys);
	end
	last_audio = audio;
	s = audio;
endtask

task automatic watch_playback(input int count);
	sample_t s;
	addr_t a;
	for (int i = 0; i < count; i++) begin
		next_sample(s);
		a = play_base + addr_t'(play_idx);
		check($sformatf("sample %0d", play_idx), int'(model_ram[a[10:0]]), int'(s));
		play_idx = (play_idx == LOOP_SIZE - 1) ? 0 : play_idx + 1;
	end
endtask

// Neighbouring samples differ across the wrap too so every fetch shows
task automatic fill_loop();
	data_t s;
	data_t prev;
	data_t first;
	prev = audio;
	first = '0;
	for (int i = 0; i < LOOP_SIZE; i++) begin
		do
			s = rand_byte();
		while (s == prev || (i == LOOP_SIZE - 1 && s == first));
		if (i == 0)
			first = s;
		ram_write(play_base + addr_t'(i), s);
		prev = s;
	end
	last_audio = audio;
endtask

task automatic host_traffic(input int count);
	addr_t a;
	for (int i = 0; i < count; i++) begin
		if ($urandom_range(0, 1) == 1) begin
			// Writes stay clear of the sample loop
			do
				a = addr_t'($urandom_range(0, int'(RAM_SIZE) - 1));
			while (a >= play_base && a < play_base + addr_t'(LOOP_SIZE));
			ram_write(a, rand_byte());
		end else begin
			ram_check(known[$urandom_range(0, known.size() - 1)]);
		end
	end
endtask

task automatic ram_readback_test();
	begin_test("ram_readback");
	for (int i = 0; i < 32; i++)
		ram_write(addr_t'($urandom_range(0, int'(RAM_SIZE) - 1)), rand_byte());
	foreach (known[i])
		ram_check(known[i]);
	end_test();
endtask

task automatic register_test();
	logic [15:0] v;
	data_t d;
	begin_test("registers");
	v = 16'($urandom());
	write_reg16(OFS_BASE, v);
	check_reg16("base", OFS_BASE, v);
	v = 16'($urandom());
	write_reg16(OFS_LENGTH, v);
	check_reg16("length", OFS_LENGTH, v & 16'h07ff);
	v = 16'($urandom());
	write_reg16(OFS_PERIOD, v);
	check_reg16("period", OFS_PERIOD, v);
	// Only the enable bit exists in CTRL
	write_ok(reg_addr(OFS_CTRL), 8'hff);
	read_ok(reg_addr(OFS_CTRL), d);
	check("ctrl set", 1, int'(d));
	write_ok(reg_addr(OFS_CTRL), 8'hfe);
	read_ok(reg_addr(OFS_CTRL), d);
	check("ctrl clear", 0, int'(d));
	end_test();
endtask

task automatic unmapped_test();
	addr_t a;
	addr_t r;
	data_t d;
	data_t rd;
	logic err;
	begin_test("unmapped");
	for (int i = 0; i < 12; i++) begin
		a = unmapped_addr();
		r = addr_t'(a[10:0]);
		d = rand_byte();
		ram_write(r, d);
		apb_access(1'b1, a, ~d, rd, err);
		check($sformatf("pslverr on write %04h", a), 1, int'(err));
		apb_access(1'b0, a, '0, rd, err);
		check($sformatf("pslverr on read %04h", a), 1, int'(err));
		ram_check(r);
	end
	end_test();
endtask

task automatic playback_test();
	data_t d;
	begin_test("playback");
	play_base = addr_t'($urandom_range(0, int'(RAM_SIZE) - LOOP_SIZE));
	play_idx = 0;
	fill_loop();
	write_reg16(OFS_BASE, play_base);
	write_reg16(OFS_LENGTH, 16'(LOOP_SIZE - 1));
	write_reg16(OFS_PERIOD, 16'd12);
	write_ok(reg_addr(OFS_CTRL), 8'h01);
	read_ok(reg_addr(OFS_CTRL), d);
	check("ctrl", 1, int'(d));
	// Two full loops ending on the last sample
	watch_playback(2 * LOOP_SIZE);
	write_ok(reg_addr(OFS_CTRL), 8'h00);
	play_idx = 0;
	end_test();
endtask

task automatic irq_test();
	data_t d;
	begin_test("irq");
	write_ok(reg_addr(OFS_STATUS), 8'h01);
	read_ok(reg_addr(OFS_STATUS), d);
	check("status after clear", 0, int'(d));
	check("irq after clear", 0, int'(irq));
	write_ok(reg_addr(OFS_CTRL), 8'h01);
	watch_playback(LOOP_SIZE - 1);
	check("irq before wrap", 0, int'(irq));
	watch_playback(1);
	check("irq at wrap", 1, int'(irq));
	watch_playback(LOOP_SIZE / 2);
	check("irq held", 1, int'(irq));
	watch_playback(LOOP_SIZE - LOOP_SIZE / 2);
	write_ok(reg_addr(OFS_CTRL), 8'h00);
	play_idx = 0;
	read_ok(reg_addr(OFS_STATUS), d);
	check("status before clear", 1, int'(d));
	write_ok(reg_addr(OFS_STATUS), 8'h01);
	check("irq cleared", 0, int'(irq));
	end_test();
endtask

task automatic contention_test();
	begin_test("contention");
	write_reg16(OFS_PERIOD, 16'd6);
	write_ok(reg_addr(OFS_CTRL), 8'h01);
	fork
		host_traffic(60);
		watch_playback(3 * LOOP_SIZE);
	join
	write_ok(reg_addr(OFS_CTRL), 8'h00);
	play_idx = 0;
	end_test();
endtask

initial begin
	n_reset_in = 1'b0;
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
	paddr = '0;
	pwdata = '0;
	error_count = 0;
	check_count = 0;
	errors_before = 0;
	tests_run = 0;
	tests_failed = 0;
	play_base = '0;
	play_idx = 0;
	test_name = "reset";
	void'($urandom(79));
	repeat (16) @(posedge sys);
	#1;
	n_reset_in = 1'b1;
	repeat (2) @(posedge sys);
	last_audio = audio;

	ram_readback_test();
	register_test();
	unmapped_test();
	playback_test();
	irq_test();
	contention_test();

	$display("%0d tests, %0d failed, %0d checks, %0d errors",
		tests_run, tests_failed, check_count, error_count);
	if (error_count == 0)
		$display("Verification passed");
	else
		$display("Verification failed");
	$finish;
end

endmodule

// File: sources.f
rtl/bus_pkg.sv
rtl/audio_pkg.sv
rtl/host_bridge.sv
rtl/sample_fetcher.sv
rtl/bus_fabric.sv
rtl/system.sv
tb/system_assertions.sv
tb/tb_system.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_system \
	-f sources.f -o tb_system || { echo "Build failed"; exit 1; }

output=$(./obj_dir/tb_system)
echo "$output"
echo "$output" | grep -qx "Verification passed" && exit 0 || exit 1
